//--- cu_isa_pkg.sv
package cu_isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_BLE   = 6'h06;
    localparam opcode_t OP_BGT   = 6'h07;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SB    = 6'h28;
    localparam opcode_t OP_SH    = 6'h29;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type funct codes
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_MFHI = 6'h10;
    localparam funct_t FN_MFLO = 6'h12;
    localparam funct_t FN_MULT = 6'h18;
    localparam funct_t FN_DIV  = 6'h1a;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;

    typedef enum logic [4:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_ADDI, CLS_ADDIU,
        CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT,
        CLS_J, CLS_JAL, CLS_JR,
        CLS_LW, CLS_LH, CLS_LB, CLS_SW, CLS_SH, CLS_SB,
        CLS_MULT, CLS_DIV, CLS_MFHI, CLS_MFLO,
        CLS_INVALID
    } instr_class_e;

endpackage

//--- cu_ctrl_pkg.sv
package cu_ctrl_pkg;

    typedef enum logic [5:0] {
        S_FETCH1, S_FETCH2, S_DECODE1, S_DECODE2, S_DECODE3, S_DISPATCH,
        S_ADD, S_SUB, S_AND, S_ADDI, S_ADDIU, S_SAVE_RD, S_SAVE_RT,
        S_BEQ, S_BNE, S_BGT, S_BLE,
        S_J, S_JAL1, S_JAL2, S_JR1, S_JR2,
        S_MEM_ADDR, S_MEM_READ, S_MEM_WAIT, S_MDR_LOAD,
        S_LW, S_LH, S_LB, S_SW, S_SH, S_SB, S_STORE_WAIT,
        S_MULT, S_MULT_WAIT, S_MULT_DONE, S_DIV, S_DIV_WAIT, S_DIV_DONE,
        S_MFHI, S_MFLO,
        S_EXC_EPC, S_VEC_INV, S_VEC_OVF, S_VEC_DZ, S_EXC_WAIT, S_EXC_MDR, S_EXC_PC
    } state_e;

    typedef enum logic [1:0] {
        CAUSE_INVALID, CAUSE_OVERFLOW, CAUSE_DIV_ZERO
    } cause_e;

    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] alu_b_t;
    typedef logic [2:0] pc_src_t;
    typedef logic [2:0] reg_dst_t;
    typedef logic [3:0] wb_src_t;
    typedef logic [2:0] mem_addr_t;
    typedef logic [1:0] branch_op_t;
    typedef logic [1:0] size_t;

    localparam logic SRC_A_PC  = 1'b0;
    localparam logic SRC_A_REG = 1'b1;

    localparam alu_op_t ALU_PASS = 3'b000;
    localparam alu_op_t ALU_ADD  = 3'b001;
    localparam alu_op_t ALU_SUB  = 3'b010;
    localparam alu_op_t ALU_AND  = 3'b011;
    localparam alu_op_t ALU_CMP  = 3'b111;

    localparam alu_b_t ALU_B_REG   = 2'b00;
    localparam alu_b_t ALU_B_FOUR  = 2'b01;
    localparam alu_b_t ALU_B_IMM   = 2'b10;
    localparam alu_b_t ALU_B_SHIFT = 2'b11; // Immediate shifted left by 2

    localparam pc_src_t PC_ALU_RES = 3'b000;
    localparam pc_src_t PC_ALU_OUT = 3'b001;
    localparam pc_src_t PC_JUMP    = 3'b010;
    localparam pc_src_t PC_VECTOR  = 3'b110;

    localparam reg_dst_t DST_RT = 3'b000;
    localparam reg_dst_t DST_RA = 3'b010;
    localparam reg_dst_t DST_RD = 3'b011;

    localparam wb_src_t WB_ALU_OUT = 4'b0000;
    localparam wb_src_t WB_MDR     = 4'b0001;
    localparam wb_src_t WB_HI      = 4'b0010;
    localparam wb_src_t WB_LO      = 4'b0011;

    localparam mem_addr_t ADDR_PC      = 3'b000;
    localparam mem_addr_t ADDR_ALU_OUT = 3'b001;
    localparam mem_addr_t ADDR_VEC_INV = 3'b010;
    localparam mem_addr_t ADDR_VEC_OVF = 3'b011;
    localparam mem_addr_t ADDR_VEC_DZ  = 3'b100;

    localparam branch_op_t BR_EQ = 2'b00;
    localparam branch_op_t BR_NE = 2'b01;
    localparam branch_op_t BR_GT = 2'b10;
    localparam branch_op_t BR_LE = 2'b11;

    localparam size_t SIZE_WORD = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_BYTE = 2'b11;

    localparam logic HILO_DIV  = 1'b0;
    localparam logic HILO_MULT = 1'b1;

    typedef struct packed {
        logic   src_a;
        alu_b_t src_b;
        alu_op_t op;
    } alu_ctrl_t;

    typedef struct packed {
        logic      wr;
        mem_addr_t addr_sel;
        logic      mdr_load;
        size_t     load_size;
        size_t     store_size;
    } mem_ctrl_t;

    typedef struct packed {
        logic     regwrite;
        reg_dst_t dst;
        wb_src_t  wb_src;
        logic     ir_load;
        logic     ab_load;
        logic     aluout_load;
    } reg_ctrl_t;

    typedef struct packed {
        logic       write;
        logic       write_cond;
        pc_src_t    source;
        branch_op_t branch_op;
        logic       epc_load;
    } pc_ctrl_t;

    typedef struct packed {
        logic div_start;
        logic mult_start;
        logic hilo_load;
        logic hilo_src;
    } muldiv_ctrl_t;

endpackage

//--- instr_decoder.sv
module instr_decoder (
    input  cu_isa_pkg::opcode_t      op,
    input  cu_isa_pkg::funct_t       funct,
    output cu_isa_pkg::instr_class_e cls
);
    import cu_isa_pkg::*;

    always_comb begin
        cls = CLS_INVALID;
        if (op == OP_RTYPE) begin
            case (funct)
                FN_ADD:  cls = CLS_ADD;
                FN_SUB:  cls = CLS_SUB;
                FN_AND:  cls = CLS_AND;
                FN_JR:   cls = CLS_JR;
                FN_MULT: cls = CLS_MULT;
                FN_DIV:  cls = CLS_DIV;
                FN_MFHI: cls = CLS_MFHI;
                FN_MFLO: cls = CLS_MFLO;
                default: cls = CLS_INVALID;
            endcase
        end else begin
            case (op)
                OP_ADDI:  cls = CLS_ADDI;
                OP_ADDIU: cls = CLS_ADDIU;
                OP_BEQ:   cls = CLS_BEQ;
                OP_BNE:   cls = CLS_BNE;
                OP_BLE:   cls = CLS_BLE;
                OP_BGT:   cls = CLS_BGT;
                OP_J:     cls = CLS_J;
                OP_JAL:   cls = CLS_JAL;
                OP_LW:    cls = CLS_LW;
                OP_LH:    cls = CLS_LH;
                OP_LB:    cls = CLS_LB;
                OP_SW:    cls = CLS_SW;
                OP_SH:    cls = CLS_SH;
                OP_SB:    cls = CLS_SB;
                default:  cls = CLS_INVALID; // Unknown opcode traps
            endcase
        end
    end

endmodule

//--- main_sequencer.sv
module main_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  cu_isa_pkg::instr_class_e cls,
    input  logic                     overflow,
    input  logic                     div_zero,
    input  logic                     div_stop,
    input  logic                     mult_stop,
    output cu_ctrl_pkg::state_e      state,
    output cu_ctrl_pkg::state_e      next_state
);
    import cu_isa_pkg::*;
    import cu_ctrl_pkg::*;

    cause_e cause;
    cause_e cause_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH1;
            cause <= CAUSE_INVALID;
        end else begin
            state <= next_state;
            cause <= cause_next;
        end
    end

    always_comb begin
        next_state = S_FETCH1; // Most execute steps end here
        cause_next = cause;
        case (state)
            S_FETCH1:  next_state = S_FETCH2;
            S_FETCH2:  next_state = S_DECODE1;
            S_DECODE1: next_state = S_DECODE2;
            S_DECODE2: next_state = S_DECODE3;
            S_DECODE3: next_state = S_DISPATCH;
            S_DISPATCH: begin
                case (cls)
                    CLS_ADD:   next_state = S_ADD;
                    CLS_SUB:   next_state = S_SUB;
                    CLS_AND:   next_state = S_AND;
                    CLS_ADDI:  next_state = S_ADDI;
                    CLS_ADDIU: next_state = S_ADDIU;
                    CLS_BEQ:   next_state = S_BEQ;
                    CLS_BNE:   next_state = S_BNE;
                    CLS_BGT:   next_state = S_BGT;
                    CLS_BLE:   next_state = S_BLE;
                    CLS_J:     next_state = S_J;
                    CLS_JAL:   next_state = S_JAL1;
                    CLS_JR:    next_state = S_JR1;
                    CLS_MULT:  next_state = S_MULT;
                    CLS_DIV:   next_state = S_DIV;
                    CLS_MFHI:  next_state = S_MFHI;
                    CLS_MFLO:  next_state = S_MFLO;
                    CLS_LW, CLS_LH, CLS_LB,
                    CLS_SW, CLS_SH, CLS_SB: next_state = S_MEM_ADDR;
                    default: begin
                        next_state = S_EXC_EPC;
                        cause_next = CAUSE_INVALID;
                    end
                endcase
            end
            S_ADD, S_SUB, S_AND: next_state = S_SAVE_RD;
            S_ADDI, S_ADDIU:     next_state = S_SAVE_RT;
            S_SAVE_RD: begin
                if (overflow && (cls inside {CLS_ADD, CLS_SUB})) begin
                    next_state = S_EXC_EPC;
                    cause_next = CAUSE_OVERFLOW;
                end
            end
            S_SAVE_RT: begin
                if (overflow && cls == CLS_ADDI) begin // addiu never traps
                    next_state = S_EXC_EPC;
                    cause_next = CAUSE_OVERFLOW;
                end
            end
            S_JAL1:     next_state = S_JAL2;
            S_JAL2:     next_state = S_J;
            S_JR1:      next_state = S_JR2;
            S_MEM_ADDR: next_state = S_MEM_READ;
            S_MEM_READ: next_state = S_MEM_WAIT;
            S_MEM_WAIT: next_state = S_MDR_LOAD;
            S_MDR_LOAD: begin
                case (cls)
                    CLS_LW:  next_state = S_LW;
                    CLS_LH:  next_state = S_LH;
                    CLS_LB:  next_state = S_LB;
                    CLS_SW:  next_state = S_SW;
                    CLS_SH:  next_state = S_SH;
                    default: next_state = S_SB;
                endcase
            end
            S_SW, S_SH, S_SB: next_state = S_STORE_WAIT;
            S_MULT:           next_state = S_MULT_WAIT;
            S_MULT_WAIT:      next_state = mult_stop ? S_MULT_DONE : S_MULT_WAIT;
            S_DIV:            next_state = S_DIV_WAIT;
            S_DIV_WAIT: begin
                if (div_zero) begin
                    next_state = S_EXC_EPC;
                    cause_next = CAUSE_DIV_ZERO;
                end else begin
                    next_state = div_stop ? S_DIV_DONE : S_DIV_WAIT;
                end
            end
            S_EXC_EPC: begin
                case (cause)
                    CAUSE_OVERFLOW: next_state = S_VEC_OVF;
                    CAUSE_DIV_ZERO: next_state = S_VEC_DZ;
                    default:        next_state = S_VEC_INV;
                endcase
            end
            S_VEC_INV, S_VEC_OVF, S_VEC_DZ: next_state = S_EXC_WAIT;
            S_EXC_WAIT: next_state = S_EXC_MDR;
            S_EXC_MDR:  next_state = S_EXC_PC;
            default:    next_state = S_FETCH1;
        endcase
    end

endmodule

//--- control_word_gen.sv
module control_word_gen (
    input  logic                      clk,
    input  logic                      reset,
    input  cu_ctrl_pkg::state_e       state,
    input  cu_ctrl_pkg::state_e       next_state,
    output cu_ctrl_pkg::alu_ctrl_t    alu,
    output cu_ctrl_pkg::mem_ctrl_t    mem,
    output cu_ctrl_pkg::reg_ctrl_t    regs,
    output cu_ctrl_pkg::pc_ctrl_t     pc,
    output cu_ctrl_pkg::muldiv_ctrl_t muldiv
);
    import cu_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu    <= '0;
            mem    <= '0;
            regs   <= '0;
            pc     <= '0;
            muldiv <= '0;
        end else begin
            // Strobes drop unless the state raises them again
            mem.wr            <= 1'b0;
            mem.mdr_load      <= 1'b0;
            regs.regwrite     <= 1'b0;
            regs.ir_load      <= 1'b0;
            regs.ab_load      <= 1'b0;
            regs.aluout_load  <= 1'b0;
            pc.write          <= 1'b0;
            pc.write_cond     <= 1'b0;
            pc.epc_load       <= 1'b0;
            muldiv.div_start  <= 1'b0;
            muldiv.mult_start <= 1'b0;
            muldiv.hilo_load  <= 1'b0;

            case (state)
                S_FETCH1: mem.addr_sel <= ADDR_PC;
                S_FETCH2: begin // PC + 4
                    alu.src_a <= SRC_A_PC;
                    alu.src_b <= ALU_B_FOUR;
                    alu.op    <= ALU_ADD;
                    pc.source <= PC_ALU_RES;
                    pc.write  <= 1'b1;
                end
                S_DECODE1: regs.ir_load <= 1'b1;
                S_DECODE2: regs.ab_load <= 1'b1;
                S_DECODE3: begin
                    alu.src_a        <= SRC_A_PC;
                    alu.src_b        <= ALU_B_SHIFT;
                    alu.op           <= ALU_ADD;
                    regs.aluout_load <= 1'b1; // Branch target parked in ALU-out
                end
                S_ADD, S_SUB, S_AND, S_ADDI, S_ADDIU: begin
                    alu.src_a <= SRC_A_REG;
                    alu.src_b <= (state inside {S_ADDI, S_ADDIU}) ? ALU_B_IMM : ALU_B_REG;
                    alu.op    <= (state == S_SUB) ? ALU_SUB :
                                 (state == S_AND) ? ALU_AND : ALU_ADD;
                    regs.aluout_load <= 1'b1;
                end
                S_SAVE_RD, S_SAVE_RT: begin
                    regs.dst      <= (state == S_SAVE_RD) ? DST_RD : DST_RT;
                    regs.wb_src   <= WB_ALU_OUT;
                    regs.regwrite <= (next_state == S_FETCH1); // Held back on overflow
                end
                S_BEQ, S_BNE, S_BGT, S_BLE: begin
                    alu.src_a     <= SRC_A_REG;
                    alu.src_b     <= ALU_B_REG;
                    alu.op        <= ALU_CMP;
                    pc.source     <= PC_ALU_OUT;
                    pc.branch_op  <= (state == S_BEQ) ? BR_EQ : (state == S_BNE) ? BR_NE :
                                     (state == S_BGT) ? BR_GT : BR_LE;
                    pc.write_cond <= 1'b1;
                end
                S_J: begin
                    pc.source <= PC_JUMP;
                    pc.write  <= 1'b1;
                end
                S_JAL1: begin
                    alu.src_a        <= SRC_A_PC;
                    alu.op           <= ALU_PASS;
                    regs.aluout_load <= 1'b1;
                end
                S_JAL2: begin
                    regs.dst      <= DST_RA;
                    regs.wb_src   <= WB_ALU_OUT;
                    regs.regwrite <= 1'b1;
                end
                S_JR1: begin
                    alu.src_a <= SRC_A_REG;
                    alu.op    <= ALU_PASS;
                end
                S_JR2: begin
                    pc.source <= PC_ALU_RES;
                    pc.write  <= 1'b1;
                end
                S_MEM_ADDR: begin
                    alu.src_a        <= SRC_A_REG;
                    alu.src_b        <= ALU_B_IMM;
                    alu.op           <= ALU_ADD;
                    regs.aluout_load <= 1'b1;
                end
                S_MEM_READ: mem.addr_sel <= ADDR_ALU_OUT;
                S_MDR_LOAD: mem.mdr_load <= 1'b1;
                S_LW, S_LH, S_LB: begin
                    mem.load_size <= (state == S_LW) ? SIZE_WORD :
                                     (state == S_LH) ? SIZE_HALF : SIZE_BYTE;
                    regs.dst      <= DST_RT;
                    regs.wb_src   <= WB_MDR;
                    regs.regwrite <= 1'b1;
                end
                S_SW, S_SH, S_SB: begin
                    mem.store_size <= (state == S_SW) ? SIZE_WORD :
                                      (state == S_SH) ? SIZE_HALF : SIZE_BYTE;
                    mem.addr_sel   <= ADDR_ALU_OUT;
                    mem.wr         <= 1'b1;
                end
                S_MULT:      muldiv.mult_start <= 1'b1;
                S_DIV:       muldiv.div_start  <= 1'b1;
                S_MULT_DONE, S_DIV_DONE: begin
                    muldiv.hilo_src  <= (state == S_MULT_DONE) ? HILO_MULT : HILO_DIV;
                    muldiv.hilo_load <= 1'b1;
                end
                S_MFHI, S_MFLO: begin
                    regs.dst      <= DST_RD;
                    regs.wb_src   <= (state == S_MFHI) ? WB_HI : WB_LO;
                    regs.regwrite <= 1'b1;
                end
                S_EXC_EPC: begin // EPC gets PC - 4
                    alu.src_a   <= SRC_A_PC;
                    alu.src_b   <= ALU_B_FOUR;
                    alu.op      <= ALU_SUB;
                    pc.epc_load <= 1'b1;
                end
                S_VEC_INV, S_VEC_OVF, S_VEC_DZ: begin
                    mem.addr_sel <= (state == S_VEC_INV) ? ADDR_VEC_INV :
                                    (state == S_VEC_OVF) ? ADDR_VEC_OVF : ADDR_VEC_DZ;
                end
                S_EXC_MDR: begin
                    mem.mdr_load  <= 1'b1;
                    mem.load_size <= SIZE_BYTE; // Vector entry is one byte
                    pc.source     <= PC_VECTOR;
                end
                S_EXC_PC: pc.write <= 1'b1;
                default: ; // Wait states only hold selects
            endcase
        end
    end

endmodule

//--- control_unit.sv
module control_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  cu_isa_pkg::opcode_t       op,
    input  cu_isa_pkg::funct_t        funct,
    input  logic                      overflow,
    input  logic                      div_zero,
    input  logic                      div_stop,
    input  logic                      mult_stop,
    output cu_ctrl_pkg::alu_ctrl_t    alu,
    output cu_ctrl_pkg::mem_ctrl_t    mem,
    output cu_ctrl_pkg::reg_ctrl_t    regs,
    output cu_ctrl_pkg::pc_ctrl_t     pc,
    output cu_ctrl_pkg::muldiv_ctrl_t muldiv
);
    import cu_isa_pkg::*;
    import cu_ctrl_pkg::*;

    instr_class_e cls;
    state_e       state;
    state_e       next_state;

    instr_decoder u_decoder (
        .op    (op),
        .funct (funct),
        .cls   (cls)
    );

    main_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .cls        (cls),
        .overflow   (overflow),
        .div_zero   (div_zero),
        .div_stop   (div_stop),
        .mult_stop  (mult_stop),
        .state      (state),
        .next_state (next_state)
    );

    control_word_gen u_word_gen (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .next_state (next_state),
        .alu        (alu),
        .mem        (mem),
        .regs       (regs),
        .pc         (pc),
        .muldiv     (muldiv)
    );

endmodule

//--- control_unit_checker.sv
module control_unit_checker (
    input logic                      clk,
    input logic                      reset,
    input cu_ctrl_pkg::mem_ctrl_t    mem,
    input cu_ctrl_pkg::reg_ctrl_t    regs,
    input cu_ctrl_pkg::pc_ctrl_t     pc,
    input cu_ctrl_pkg::muldiv_ctrl_t muldiv
);
    logic [11:0] strobes;

    assign strobes = {mem.wr, mem.mdr_load, regs.regwrite, regs.ir_load,
                      regs.ab_load, regs.aluout_load, pc.write, pc.write_cond,
                      pc.epc_load, muldiv.div_start, muldiv.mult_start, muldiv.hilo_load};

    pc_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pc.write && pc.write_cond))
        else $error("pc.write and pc.write_cond asserted together");

    mult_start_pulse: assert property (@(posedge clk) disable iff (reset)
        muldiv.mult_start |=> !muldiv.mult_start)
        else $error("mult_start held longer than one cycle");

    div_start_pulse: assert property (@(posedge clk) disable iff (reset)
        muldiv.div_start |=> !muldiv.div_start)
        else $error("div_start held longer than one cycle");

    no_write_on_epc: assert property (@(posedge clk) disable iff (reset)
        !(regs.regwrite && pc.epc_load))
        else $error("regwrite coincides with epc_load");

    // Sync reset clears every strobe on the next edge
    strobes_clear_after_reset: assert property (@(posedge clk)
        reset |=> (strobes == '0))
        else $error("strobe still set after reset");

endmodule

bind control_unit control_unit_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .mem    (mem),
    .regs   (regs),
    .pc     (pc),
    .muldiv (muldiv)
);

//--- control_unit_tb.sv
module control_unit_tb;
    import cu_isa_pkg::*;
    import cu_ctrl_pkg::*;

    localparam int WAIT_LIMIT = 64;

    // Commit kinds
    localparam logic [15:0] K_REGW = 16'd0;
    localparam logic [15:0] K_PCW  = 16'd1;
    localparam logic [15:0] K_PCWC = 16'd2;
    localparam logic [15:0] K_WR   = 16'd3;
    localparam logic [15:0] K_HILO = 16'd4;
    localparam logic [15:0] K_EXC  = 16'd5;

    localparam logic [15:0] M_ALU = 16'h0fe7; // dst, wb_src, alu op
    localparam logic [15:0] M_LD  = 16'h0ff8; // dst, wb_src, load size
    localparam logic [15:0] M_DW  = 16'h0fe0; // dst, wb_src
    localparam logic [15:0] M_ALL = 16'hffff;

    logic         clk;
    logic         reset;
    opcode_t      op;
    funct_t       funct;
    logic         overflow;
    logic         div_zero;
    logic         div_stop;
    logic         mult_stop;
    alu_ctrl_t    alu;
    mem_ctrl_t    mem;
    reg_ctrl_t    regs;
    pc_ctrl_t     pc;
    muldiv_ctrl_t muldiv;

    string       t_name[$];
    opcode_t     t_op[$];
    funct_t      t_funct[$];
    logic        t_ovf[$];
    logic        t_dz[$];
    logic [15:0] t_kind[$];
    logic [15:0] t_exp[$];
    logic [15:0] t_mask[$];
    logic        t_follow[$];
    pc_src_t     t_fsrc[$];

    int          errors;
    int          failed_tests;
    logic        timed_out;
    logic [31:0] rng_state;

    control_unit dut (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .funct     (funct),
        .overflow  (overflow),
        .div_zero  (div_zero),
        .div_stop  (div_stop),
        .mult_stop (mult_stop),
        .alu       (alu),
        .mem       (mem),
        .regs      (regs),
        .pc        (pc),
        .muldiv    (muldiv)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] regw_word(input reg_dst_t d, input wb_src_t w,
                                              input size_t s, input alu_op_t o);
        return {4'b0, d, w, s, o};
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic add_test(input string n, input opcode_t o, input funct_t f,
                            input logic ovf, input logic dz, input logic [15:0] kind,
                            input logic [15:0] exp, input logic [15:0] mask,
                            input logic follow, input pc_src_t fsrc);
        t_name.push_back(n);
        t_op.push_back(o);
        t_funct.push_back(f);
        t_ovf.push_back(ovf);
        t_dz.push_back(dz);
        t_kind.push_back(kind);
        t_exp.push_back(exp);
        t_mask.push_back(mask);
        t_follow.push_back(follow);
        t_fsrc.push_back(fsrc);
    endtask

    task automatic build_table();
        add_test("add", OP_RTYPE, FN_ADD, 0, 0, K_REGW,
                 regw_word(DST_RD, WB_ALU_OUT, SIZE_WORD, ALU_ADD), M_ALU, 0, PC_ALU_RES);
        add_test("sub", OP_RTYPE, FN_SUB, 0, 0, K_REGW,
                 regw_word(DST_RD, WB_ALU_OUT, SIZE_WORD, ALU_SUB), M_ALU, 0, PC_ALU_RES);
        add_test("and", OP_RTYPE, FN_AND, 0, 0, K_REGW,
                 regw_word(DST_RD, WB_ALU_OUT, SIZE_WORD, ALU_AND), M_ALU, 0, PC_ALU_RES);
        add_test("addi", OP_ADDI, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RT, WB_ALU_OUT, SIZE_WORD, ALU_ADD), M_ALU, 0, PC_ALU_RES);
        add_test("addiu", OP_ADDIU, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RT, WB_ALU_OUT, SIZE_WORD, ALU_ADD), M_ALU, 0, PC_ALU_RES);
        add_test("add_ovf", OP_RTYPE, FN_ADD, 1, 0, K_EXC, {13'b0, ADDR_VEC_OVF}, M_ALL,
                 1, PC_VECTOR);
        add_test("addi_ovf", OP_ADDI, 6'h00, 1, 0, K_EXC, {13'b0, ADDR_VEC_OVF}, M_ALL,
                 1, PC_VECTOR);
        add_test("addiu_ovf", OP_ADDIU, 6'h00, 1, 0, K_REGW,
                 regw_word(DST_RT, WB_ALU_OUT, SIZE_WORD, ALU_ADD), M_ALU, 0, PC_ALU_RES);
        add_test("beq", OP_BEQ, 6'h00, 0, 0, K_PCWC, {11'b0, BR_EQ, PC_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("bne", OP_BNE, 6'h00, 0, 0, K_PCWC, {11'b0, BR_NE, PC_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("bgt", OP_BGT, 6'h00, 0, 0, K_PCWC, {11'b0, BR_GT, PC_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("ble", OP_BLE, 6'h00, 0, 0, K_PCWC, {11'b0, BR_LE, PC_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("j", OP_J, 6'h00, 0, 0, K_PCW, {13'b0, PC_JUMP}, M_ALL, 0, PC_ALU_RES);
        add_test("jal", OP_JAL, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RA, WB_ALU_OUT, SIZE_WORD, ALU_PASS), M_DW, 1, PC_JUMP);
        add_test("jr", OP_RTYPE, FN_JR, 0, 0, K_PCW, {13'b0, PC_ALU_RES}, M_ALL,
                 0, PC_ALU_RES);
        add_test("lw", OP_LW, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RT, WB_MDR, SIZE_WORD, ALU_PASS), M_LD, 0, PC_ALU_RES);
        add_test("lh", OP_LH, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RT, WB_MDR, SIZE_HALF, ALU_PASS), M_LD, 0, PC_ALU_RES);
        add_test("lb", OP_LB, 6'h00, 0, 0, K_REGW,
                 regw_word(DST_RT, WB_MDR, SIZE_BYTE, ALU_PASS), M_LD, 0, PC_ALU_RES);
        add_test("sw", OP_SW, 6'h00, 0, 0, K_WR, {11'b0, SIZE_WORD, ADDR_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("sh", OP_SH, 6'h00, 0, 0, K_WR, {11'b0, SIZE_HALF, ADDR_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("sb", OP_SB, 6'h00, 0, 0, K_WR, {11'b0, SIZE_BYTE, ADDR_ALU_OUT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("mult", OP_RTYPE, FN_MULT, 0, 0, K_HILO, {15'b0, HILO_MULT}, M_ALL,
                 0, PC_ALU_RES);
        add_test("div", OP_RTYPE, FN_DIV, 0, 0, K_HILO, {15'b0, HILO_DIV}, M_ALL,
                 0, PC_ALU_RES);
        add_test("mfhi", OP_RTYPE, FN_MFHI, 0, 0, K_REGW,
                 regw_word(DST_RD, WB_HI, SIZE_WORD, ALU_PASS), M_DW, 0, PC_ALU_RES);
        add_test("mflo", OP_RTYPE, FN_MFLO, 0, 0, K_REGW,
                 regw_word(DST_RD, WB_LO, SIZE_WORD, ALU_PASS), M_DW, 0, PC_ALU_RES);
        add_test("div_zero", OP_RTYPE, FN_DIV, 0, 1, K_EXC, {13'b0, ADDR_VEC_DZ}, M_ALL,
                 1, PC_VECTOR);
        add_test("bad_opcode", 6'h3f, 6'h00, 0, 0, K_EXC, {13'b0, ADDR_VEC_INV}, M_ALL,
                 1, PC_VECTOR);
        add_test("bad_funct", OP_RTYPE, 6'h3f, 0, 0, K_EXC, {13'b0, ADDR_VEC_INV}, M_ALL,
                 1, PC_VECTOR);
    endtask

    task automatic run_test(input int i);
        logic [15:0] kind;
        logic [15:0] value;
        logic        seen;
        logic        stop_is_mult;
        logic        stop_raised;
        int          cyc;
        int          starts;
        int          delay;
        int          errs_before;
        errs_before = errors;
        kind = 16'hffff;
        value = 16'h0;
        seen = 1'b0;
        stop_is_mult = 1'b0;
        stop_raised = 1'b0;
        starts = 0;
        delay = -1;
        @(posedge clk);
        op        <= t_op[i];
        funct     <= t_funct[i];
        overflow  <= t_ovf[i];
        div_zero  <= t_dz[i];
        mult_stop <= 1'b0;
        div_stop  <= 1'b0;

        // Instruction register load marks the start of this instruction
        cyc = 0;
        while (!seen && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            seen = regs.ir_load;
            cyc++;
        end
        if (!seen) begin
            $display("Timeout: no instruction fetch in test %s", t_name[i]);
            timed_out = 1'b1;
            return;
        end

        seen = 1'b0;
        cyc = 0;
        while (!seen && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            if (delay == 0) begin
                mult_stop <= stop_is_mult;
                div_stop  <= !stop_is_mult;
                stop_raised = 1'b1;
                delay = -1;
            end else if (delay > 0) begin
                delay--;
            end
            @(negedge clk);
            cyc++;
            if (muldiv.mult_start || muldiv.div_start) begin
                starts++;
                stop_is_mult = muldiv.mult_start;
                rng_state = lcg_next(rng_state);
                delay = int'(rng_state[18:16]); // 1 to 8 cycles until stop
            end
            seen = 1'b1;
            if (pc.epc_load) kind = K_EXC;
            else if (regs.regwrite) kind = K_REGW;
            else if (pc.write) kind = K_PCW;
            else if (pc.write_cond) kind = K_PCWC;
            else if (mem.wr) kind = K_WR;
            else if (muldiv.hilo_load) kind = K_HILO;
            else seen = 1'b0;
        end
        if (!seen) begin
            $display("Timeout: no commit strobe in test %s", t_name[i]);
            timed_out = 1'b1;
            return;
        end

        case (kind)
            K_REGW:  value = regw_word(regs.dst, regs.wb_src, mem.load_size, alu.op);
            K_PCW:   value = {13'b0, pc.source};
            K_PCWC:  value = {11'b0, pc.branch_op, pc.source};
            K_WR:    value = {11'b0, mem.store_size, mem.addr_sel};
            K_HILO:  value = {15'b0, muldiv.hilo_src};
            default: begin
                @(negedge clk); // Vector select follows epc_load
                value = {13'b0, mem.addr_sel};
                check({t_name[i], " epc pulse"}, 16'd0, {15'b0, pc.epc_load});
            end
        endcase
        check({t_name[i], " kind"}, t_kind[i], kind);
        check({t_name[i], " fields"}, t_exp[i] & t_mask[i], value & t_mask[i]);
        if (t_kind[i] == K_HILO) begin
            check({t_name[i], " starts"}, 16'd1, 16'(starts));
            check({t_name[i], " stop before hilo"}, 16'd1, {15'b0, stop_raised});
        end

        if (t_follow[i]) begin
            seen = 1'b0;
            cyc = 0;
            while (!seen && cyc < WAIT_LIMIT) begin
                @(negedge clk);
                cyc++;
                if (regs.regwrite) begin
                    $display("Unexpected register write before the PC update in test %s",
                             t_name[i]);
                    errors++;
                end
                seen = pc.write;
            end
            if (!seen) begin
                $display("Timeout: no PC write after commit in test %s", t_name[i]);
                timed_out = 1'b1;
                return;
            end
            check({t_name[i], " pc source"}, {13'b0, t_fsrc[i]}, {13'b0, pc.source});
        end

        if (errors > errs_before) begin
            failed_tests++;
            $display("test %s: failed", t_name[i]);
        end else begin
            $display("test %s: ok", t_name[i]);
        end
    endtask

    initial begin
        reset = 1'b1;
        op = OP_RTYPE;
        funct = FN_ADD;
        overflow = 1'b0;
        div_zero = 1'b0;
        div_stop = 1'b0;
        mult_stop = 1'b0;
        errors = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        rng_state = 32'hed254e6a;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
            if (timed_out) break;
        end
        $display("tests run %0d, failed %0d, check errors %0d",
                 t_name.size(), failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
cu_isa_pkg.sv
cu_ctrl_pkg.sv
instr_decoder.sv
main_sequencer.sv
control_word_gen.sv
control_unit.sv
control_unit_checker.sv
control_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator and run; the pass line in the output decides the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module control_unit_tb -f filelist.f -o control_unit_sim &&
./obj_dir/control_unit_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" &&
exit 0 ||
{ echo "simulation failed"; exit 1; }
